// ==== launcher_defines.svh ====
`ifndef LAUNCHER_DEFINES_SVH
`define LAUNCHER_DEFINES_SVH

////////////////////////////////////////
// A/D converters
////////////////////////////////////////
`define ADC_BITS      12     // Bits per sample
`define ADC_PERIOD    16     // Clocks per conversion, one cs pulse each

// Offsets added to the held words
`define BIAS_A0       5      // Output current
`define BIAS_A1       5      // Cap voltage
`define BIAS_B0       5      // Spare
`define BIAS_B1       6      // Output voltage

////////////////////////////////////////
// Resistance divider
////////////////////////////////////////
`define DIV_LATENCY   17     // Strobe to result valid
`define MIN_CURRENT   32     // Decoded DN, below this no reading

////////////////////////////////////////
// Continuity meter
////////////////////////////////////////
`define HOLDOFF_BITS  25     // Retrigger period is the counter wrap
`define TEST_PULSE    96     // Pulse high for holdoff 1 to 95
`define SETTLE_END    257    // First holdoff count that accumulates
`define ACCUM_END     4096   // End of accumulation and open check
`define OPEN_CODE     'h3DC  // Decoded open circuit marker
`define LED_LO        'h020  // 1 ohm in 6.5 format
`define LED_HI        'h200  // 16 ohms in 6.5 format

`endif

// ==== launcher_pkg.sv ====
`default_nettype none

`include "launcher_defines.svh"

package launcher_pkg;

	typedef logic [`ADC_BITS-1:0] adc_word_t;  // Raw A/D sign format
	typedef logic [`ADC_BITS-2:0] adc_mag_t;   // Decoded magnitude, positive only
	typedef logic [`ADC_BITS-1:0] ohms_t;      // A/D format, 6.5 ohms once decoded

	// One conversion of all four channels
	typedef struct packed {
		adc_word_t a0; // Output current
		adc_word_t a1; // Cap voltage
		adc_word_t b0; // Spare
		adc_word_t b1; // Output voltage
	} adc_frame_t;

	typedef struct packed {
		logic  valid; // One cycle pulse per good reading
		ohms_t ohms;
	} ohms_result_t;

	// Negative half clips to zero
	function automatic adc_mag_t adc_decode(input adc_word_t w);
		return w[`ADC_BITS-1] ? '0 : ~w[`ADC_BITS-2:0];
	endfunction

	function automatic adc_word_t adc_encode(input adc_mag_t m);
		return {1'b0, ~m}; // Back to A/D format
	endfunction

endpackage

`default_nettype wire

// ==== adc_serial_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "launcher_defines.svh"

module adc_serial_rx (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic [1:0]          i_ad_sdata_a, // [0] current, [1] cap volts
	input  wire logic [1:0]          i_ad_sdata_b, // [0] spare, [1] output volts
	output logic                     o_ad_cs,
	output launcher_pkg::adc_frame_t o_frame,
	output logic                     o_strobe
);

	localparam int DIV_W      = $clog2(`ADC_PERIOD);
	localparam int NUM_CH     = 4;
	localparam int LOAD_TAP   = 0;                         // Starts the load walk
	localparam int HOLD_TAP   = LOAD_TAP + `ADC_BITS + 1;  // After bit 0 lands
	localparam int STROBE_TAP = `ADC_PERIOD - 1;           // One edge after hold

	logic [DIV_W-1:0]                          cs_div;    // Conversion counter
	logic [`ADC_PERIOD-1:0]                    cs_dly;    // cs history
	logic [`ADC_BITS-1:0]                      load_oh;   // One hot bit select
	logic [NUM_CH-1:0]                         serial_in;
	launcher_pkg::adc_word_t [NUM_CH-1:0]      shift_w;   // Words being received
	launcher_pkg::adc_word_t [NUM_CH-1:0]      hold_w;    // Last complete frame

	////////////////////////////////////////
	// Chip select and event timing
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			cs_div  <= DIV_W'(`ADC_PERIOD - 1); // cs stays low out of reset
			cs_dly  <= '0;
			load_oh <= '0;
		end else begin
			cs_div  <= (cs_div == '0) ? DIV_W'(`ADC_PERIOD - 1) : cs_div - 1'b1;
			cs_dly  <= {cs_dly[`ADC_PERIOD-2:0], o_ad_cs};
			load_oh <= {cs_dly[LOAD_TAP], load_oh[`ADC_BITS-1:1]}; // Walks MSB to LSB
		end
	end

	assign o_ad_cs = (cs_div == '0); // One cycle in every ADC_PERIOD

	////////////////////////////////////////
	// Serial capture
	////////////////////////////////////////

	// Channel order matches the frame
	assign serial_in = {i_ad_sdata_b[1], i_ad_sdata_b[0], i_ad_sdata_a[1], i_ad_sdata_a[0]};

	always_ff @(posedge clk) begin
		for (int ch = 0; ch < NUM_CH; ch++) begin
			for (int b = 0; b < `ADC_BITS; b++) begin
				if (load_oh[b])
					shift_w[ch][b] <= serial_in[ch]; // Only the selected bit moves
			end
		end
		if (cs_dly[HOLD_TAP])
			hold_w <= shift_w; // Whole frame at once
	end

	// Bias correction on the held words
	assign o_frame.a0 = hold_w[0] + launcher_pkg::adc_word_t'(`BIAS_A0);
	assign o_frame.a1 = hold_w[1] + launcher_pkg::adc_word_t'(`BIAS_A1);
	assign o_frame.b0 = hold_w[2] + launcher_pkg::adc_word_t'(`BIAS_B0);
	assign o_frame.b1 = hold_w[3] + launcher_pkg::adc_word_t'(`BIAS_B1);

	assign o_strobe = cs_dly[STROBE_TAP]; // New frame is already stable

endmodule

`default_nettype wire

// ==== ohm_divider.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "launcher_defines.svh"

// R = V / I in native A/D units
// Radix 4 with one load cycle and then two quotient bits per cycle
module ohm_divider (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire launcher_pkg::adc_frame_t   i_frame,
	input  wire logic                       i_strobe,
	output launcher_pkg::ohms_result_t      o_result
);

	localparam int MAG_W   = `ADC_BITS - 1;
	localparam int SCALE   = 15;                 // Voltage prescale
	localparam int NUM_W   = MAG_W + SCALE + 1;  // Leading zero keeps the first pair clear
	localparam int REM_W   = MAG_W + 1;
	localparam int WIN_W   = REM_W + 2;          // Remainder plus next dividend pair
	localparam int DEN_W   = MAG_W + 2;          // Holds 3x current
	localparam int Q_W     = 30;                 // 15 steps of 2 bits
	localparam int OUT_LSB = 8;
	localparam int OUT_MSB = OUT_LSB + MAG_W - 1;
	localparam int VLD_W   = `DIV_LATENCY - 1;   // Output register adds the last cycle

	launcher_pkg::adc_mag_t cur_in, volt_in;     // Decoded at the strobe
	launcher_pkg::adc_mag_t cur_q;               // 1x current
	logic [DEN_W-1:0]       twice_q, thrice_q;
	logic [NUM_W-1:0]       numer_q;             // Dividend bits still to shift in
	logic [REM_W-1:0]       rem_q;
	logic [Q_W-1:0]         quot_q;
	logic [WIN_W-1:0]       window, trial1, trial2, trial3, rem_next;
	logic [1:0]             qbits;
	logic [VLD_W-1:0]       vld_q;
	logic                   done, cur_ok;
	launcher_pkg::adc_mag_t q_mag;
	logic                   res_valid;
	launcher_pkg::ohms_t    res_ohms;

	always_comb begin
		cur_in = launcher_pkg::adc_decode(i_frame.a0);
		if (cur_in == '0)
			cur_in = launcher_pkg::adc_mag_t'(1); // Never divide by zero
		volt_in = launcher_pkg::adc_decode(i_frame.b1);
	end

	////////////////////////////////////////
	// Trial subtraction of 2 bits per cycle
	////////////////////////////////////////

	assign window = {rem_q, numer_q[NUM_W-1 -: 2]};
	assign trial1 = window - {3'b000, cur_q};
	assign trial2 = window - {1'b0, twice_q};
	assign trial3 = window - {1'b0, thrice_q};

	always_comb begin
		if (!trial3[WIN_W-1]) begin
			qbits    = 2'd3;
			rem_next = trial3;
		end else if (!trial2[WIN_W-1]) begin
			qbits    = 2'd2;
			rem_next = trial2;
		end else if (!trial1[WIN_W-1]) begin
			qbits    = 2'd1;
			rem_next = trial1;
		end else begin
			qbits    = 2'd0; // Remainder passes through
			rem_next = window;
		end
	end

	always_ff @(posedge clk) begin
		if (i_strobe) begin // Load a new problem
			cur_q    <= cur_in;
			twice_q  <= {1'b0, cur_in, 1'b0};
			thrice_q <= {1'b0, cur_in, 1'b0} + {2'b00, cur_in};
			numer_q  <= {1'b0, volt_in, {SCALE{1'b0}}};
			rem_q    <= '0;
			quot_q   <= '0;
		end else begin
			numer_q  <= {numer_q[NUM_W-3:0], 2'b00};
			rem_q    <= rem_next[REM_W-1:0]; // Always below current
			quot_q   <= {quot_q[Q_W-3:0], qbits};
		end
	end

	////////////////////////////////////////
	// Result timing and scaling
	////////////////////////////////////////

	assign done   = vld_q[VLD_W-1];
	assign cur_ok = (cur_q > launcher_pkg::adc_mag_t'(`MIN_CURRENT)); // Enough current to trust
	assign q_mag  = (|quot_q[Q_W-1:OUT_MSB+1]) ? '0 : quot_q[OUT_MSB:OUT_LSB]; // 6.5 ohms

	always_ff @(posedge clk) begin
		if (reset) begin
			vld_q     <= '0;
			res_valid <= 1'b0;
		end else begin
			vld_q     <= {vld_q[VLD_W-2:0], i_strobe};
			res_valid <= done && cur_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (done)
			res_ohms <= launcher_pkg::adc_encode(cur_ok ? q_mag : '0);
	end

	assign o_result.valid = res_valid;
	assign o_result.ohms  = res_ohms;

endmodule

`default_nettype wire

// ==== continuity_meter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "launcher_defines.svh"

module continuity_meter (
	input  wire logic                         clk,
	input  wire logic                         reset,
	input  wire logic                         i_test_enable,
	input  wire launcher_pkg::ohms_result_t   i_result,
	output logic                              o_test_pwm,
	output launcher_pkg::ohms_t               o_igniter_res,
	output logic                              o_res_valid,
	output logic                              o_cont_led
);

	typedef logic [`HOLDOFF_BITS-1:0] holdoff_t;

	localparam int       SUM_W     = 18;  // 128 samples of 11 bits
	localparam holdoff_t PULSE_END = holdoff_t'(`TEST_PULSE);
	localparam holdoff_t SETTLE    = holdoff_t'(`SETTLE_END);
	localparam holdoff_t ACCUM     = holdoff_t'(`ACCUM_END);
	localparam holdoff_t LED_TICK  = ACCUM + 1'b1; // Result settled by now

	holdoff_t               holdoff;
	logic [SUM_W-1:0]       sum_q, sum_next;
	logic [7:0]             cnt_q, cnt_next;
	launcher_pkg::adc_mag_t sample, mean, res_mag;
	logic                   in_window, take, mean_hit, open_hit;

	////////////////////////////////////////
	// Holdoff and test pulse
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			holdoff <= '0;
		else
			holdoff <= i_test_enable ? holdoff + 1'b1 : '0; // Wrap retriggers
	end

	assign o_test_pwm = (holdoff != '0) && (holdoff < PULSE_END);

	////////////////////////////////////////
	// Averaging
	////////////////////////////////////////

	assign in_window = (holdoff >= SETTLE) && (holdoff < ACCUM);
	assign take      = in_window && i_result.valid;
	assign open_hit  = (holdoff == ACCUM) && (cnt_q <= 8'd3); // Too few readings

	always_comb begin
		sample   = launcher_pkg::adc_decode(i_result.ohms);
		sum_next = sum_q + SUM_W'(sample);
		cnt_next = (cnt_q == '1) ? cnt_q : cnt_q + 1'b1; // Saturate
		mean_hit = 1'b1;
		case (cnt_next) // Divide by the power of two
			8'd4:    mean = sum_next[12:2];
			8'd8:    mean = sum_next[13:3];
			8'd16:   mean = sum_next[14:4];
			8'd32:   mean = sum_next[15:5];
			8'd64:   mean = sum_next[16:6];
			8'd128:  mean = sum_next[17:7];
			default: begin
				mean     = '0;
				mean_hit = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt_q       <= '0;
			sum_q       <= '0;
			o_res_valid <= 1'b0;
		end else if (holdoff == '0) begin // Idle, restart the average
			cnt_q <= '0;
			sum_q <= '0;
		end else if (take) begin
			cnt_q <= cnt_next;
			sum_q <= sum_next;
			if (mean_hit)
				o_res_valid <= 1'b1; // Sticky
		end else if (open_hit) begin
			cnt_q       <= '0;
			sum_q       <= '0;
			o_res_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take && mean_hit)
			o_igniter_res <= launcher_pkg::adc_encode(mean);
		else if (open_hit)
			o_igniter_res <= launcher_pkg::adc_encode(launcher_pkg::adc_mag_t'(`OPEN_CODE));
	end

	////////////////////////////////////////
	// Continuity LED, 1 to 16 ohms
	////////////////////////////////////////

	assign res_mag = launcher_pkg::adc_decode(o_igniter_res);

	always_ff @(posedge clk) begin
		if (reset || !i_test_enable)
			o_cont_led <= 1'b0;
		else if (holdoff == LED_TICK)
			o_cont_led <= (res_mag >= launcher_pkg::adc_mag_t'(`LED_LO)) &&
			              (res_mag <  launcher_pkg::adc_mag_t'(`LED_HI));
	end

endmodule

`default_nettype wire

// ==== continuity_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module continuity_top (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic [1:0]          i_ad_sdata_a,
	input  wire logic [1:0]          i_ad_sdata_b,
	input  wire logic                i_test_enable,  // Level, high runs the meter
	output logic                     o_ad_cs,
	output launcher_pkg::adc_frame_t o_adc,          // Monitor copy of the frame
	output logic                     o_adc_strobe,
	output logic                     o_test_pwm,
	output launcher_pkg::ohms_t      o_igniter_res,
	output logic                     o_res_valid,
	output logic                     o_cont_led
);

	launcher_pkg::ohms_result_t res; // Divider to meter

	// Free running A/D front end
	adc_serial_rx u_rx (
		.clk          (clk),
		.reset        (reset),
		.i_ad_sdata_a (i_ad_sdata_a),
		.i_ad_sdata_b (i_ad_sdata_b),
		.o_ad_cs      (o_ad_cs),
		.o_frame      (o_adc),
		.o_strobe     (o_adc_strobe)
	);

	ohm_divider u_div (
		.clk      (clk),
		.reset    (reset),
		.i_frame  (o_adc),
		.i_strobe (o_adc_strobe),
		.o_result (res)
	);

	continuity_meter u_meter (
		.clk           (clk),
		.reset         (reset),
		.i_test_enable (i_test_enable),
		.i_result      (res),
		.o_test_pwm    (o_test_pwm),
		.o_igniter_res (o_igniter_res),
		.o_res_valid   (o_res_valid),
		.o_cont_led    (o_cont_led)
	);

endmodule

`default_nettype wire

// ==== continuity_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module continuity_checker (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_test_enable,
	input wire logic o_ad_cs,
	input wire logic o_adc_strobe,
	input wire logic o_test_pwm,
	input wire logic o_cont_led
);

	int          fail_count = 0; // Read by the testbench at the end
	logic [4:0]  since_cs;       // Cycles since the last cs, saturates
	logic        seen_cs;
	logic [15:0] cs_hist;        // cs history, one bit per cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			since_cs <= '0;
			seen_cs  <= 1'b0;
			cs_hist  <= '0;
		end else begin
			cs_hist <= {cs_hist[14:0], o_ad_cs};
			if (o_ad_cs) begin
				since_cs <= 5'd1;
				seen_cs  <= 1'b1;
			end else if (since_cs != '1) begin
				since_cs <= since_cs + 5'd1;
			end
		end
	end

	////////////////////////////////////////
	// A/D timing
	////////////////////////////////////////

	cs_period: assert property (@(posedge clk) disable iff (reset)
		seen_cs |-> (o_ad_cs == (since_cs == 5'd16)))
		else begin
			$error("chip select did not repeat every 16 cycles");
			fail_count++;
		end

	strobe_after_cs: assert property (@(posedge clk) disable iff (reset)
		o_adc_strobe == cs_hist[15])  // Frame strobe 16 cycles behind cs
		else begin
			$error("frame strobe not 16 cycles after chip select");
			fail_count++;
		end

	////////////////////////////////////////
	// Meter outputs
	////////////////////////////////////////

	pwm_needs_enable: assert property (@(posedge clk) disable iff (reset)
		$rose(o_test_pwm) |-> $past(i_test_enable))
		else begin
			$error("test pulse started without enable");
			fail_count++;
		end

	led_off_when_idle: assert property (@(posedge clk) disable iff (reset)
		!i_test_enable |=> !o_cont_led)  // Registered clear
		else begin
			$error("continuity LED on while enable is low");
			fail_count++;
		end

endmodule

bind continuity_top continuity_checker u_checker (
	.clk           (clk),
	.reset         (reset),
	.i_test_enable (i_test_enable),
	.o_ad_cs       (o_ad_cs),
	.o_adc_strobe  (o_adc_strobe),
	.o_test_pwm    (o_test_pwm),
	.o_cont_led    (o_cont_led)
);

`default_nettype wire

// ==== continuity_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "launcher_defines.svh"

module continuity_tb;

	localparam int MAX_CYCLES = 40000; // About twice the whole run

	logic                     clk;
	logic                     reset;
	logic [1:0]               ad_sdata_a;
	logic [1:0]               ad_sdata_b;
	logic                     test_enable;
	logic                     ad_cs;
	launcher_pkg::adc_frame_t adc;
	logic                     adc_strobe;
	logic                     test_pwm;
	launcher_pkg::ohms_t      igniter_res;
	logic                     res_valid;
	logic                     cont_led;

	launcher_pkg::adc_frame_t tx_frame;       // Words for the next conversion
	launcher_pkg::adc_frame_t conv_frame;     // Words being shifted out
	int                       ad_phase = 15;  // Negedges since cs
	int                       errors = 0;
	int                       cycles = 0;
	logic [31:0]              rnd_state;

	continuity_top UUT (
		.clk           (clk),
		.reset         (reset),
		.i_ad_sdata_a  (ad_sdata_a),
		.i_ad_sdata_b  (ad_sdata_b),
		.i_test_enable (test_enable),
		.o_ad_cs       (ad_cs),
		.o_adc         (adc),
		.o_adc_strobe  (adc_strobe),
		.o_test_pwm    (test_pwm),
		.o_igniter_res (igniter_res),
		.o_res_valid   (res_valid),
		.o_cont_led    (cont_led)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, tests did not finish", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////
	// Serial A/D model
	////////////////////////////////////////

	// Bit 11 goes out two negedges after cs, ahead of capture edge 3
	always @(negedge clk) begin
		if (ad_cs) begin
			conv_frame = tx_frame; // Snapshot at chip select
			ad_phase   = 0;
		end else if (ad_phase < 15) begin
			ad_phase++;
		end
		if (ad_phase >= 2 && ad_phase <= 13) begin
			ad_sdata_a = {conv_frame.a1[13 - ad_phase], conv_frame.a0[13 - ad_phase]};
			ad_sdata_b = {conv_frame.b1[13 - ad_phase], conv_frame.b0[13 - ad_phase]};
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Bit 11 set reads as zero, else low bits inverted
	function automatic logic [10:0] decode_sample(input logic [11:0] w);
		return w[11] ? 11'd0 : ~w[10:0];
	endfunction

	function automatic logic [11:0] encode_value(input logic [10:0] m);
		return {1'b0, ~m};
	endfunction

	// Word to send so that the biased word decodes to m
	function automatic logic [11:0] sent_word(input logic [10:0] m, input int bias);
		return encode_value(m) - 12'(bias);
	endfunction

	// Dividend is the volts followed by 18 zero bits, 30 bit quotient
	function automatic logic [11:0] expected_ohms(input logic [11:0] cur_w,
	                                              input logic [11:0] volt_w);
		logic [10:0] cur;
		logic [29:0] quot;
		cur = decode_sample(cur_w);
		if (cur == 11'd0)
			cur = 11'd1;
		quot = (30'(decode_sample(volt_w)) << 18) / 30'(cur);
		if (quot[29:19] != '0)
			return encode_value(11'd0); // Too large, clips to zero
		return encode_value(quot[18:8]);
	endfunction

	task automatic check_value(input string name, input logic [11:0] exp_v,
	                           input logic [11:0] act_v);
		assert (act_v === exp_v) else begin
			errors++;
			$display("mismatch at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
		end
	endtask

	// Counts negedges up to the next frame strobe
	task automatic wait_strobe(output int waited);
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!adc_strobe && waited < 40);
		assert (adc_strobe) else begin
			errors++;
			$display("no frame strobe within %0d cycles at %0t", waited, $time);
		end
	endtask

	task automatic drop_enable();
		test_enable = 1'b0;
		@(negedge clk);
		check_value("o_cont_led", 12'd0, 12'(cont_led)); // Cleared one cycle later
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic check_reset_state();
		check_value("o_ad_cs", 12'd0, 12'(ad_cs));
		check_value("o_adc_strobe", 12'd0, 12'(adc_strobe));
		check_value("o_test_pwm", 12'd0, 12'(test_pwm));
		check_value("o_cont_led", 12'd0, 12'(cont_led));
		check_value("o_res_valid", 12'd0, 12'(res_valid));
	endtask

	task automatic receive_frames(input int sets);
		launcher_pkg::adc_frame_t words;
		int                       waited;
		for (int s = 0; s < sets; s++) begin
			rnd_state = xorshift32(rnd_state);
			words.a0  = rnd_state[11:0];
			words.a1  = rnd_state[23:12];
			rnd_state = xorshift32(rnd_state);
			words.b0  = rnd_state[11:0];
			words.b1  = rnd_state[23:12];
			@(negedge clk);
			while (ad_cs)
				@(negedge clk);
			tx_frame = words; // Never on a cs negedge
			do
				@(negedge clk);
			while (!ad_cs);
			wait_strobe(waited);
			check_value("strobe delay", 12'd16, 12'(waited));
			check_value("o_adc.a0", words.a0 + 12'(`BIAS_A0), adc.a0);
			check_value("o_adc.a1", words.a1 + 12'(`BIAS_A1), adc.a1);
			check_value("o_adc.b0", words.b0 + 12'(`BIAS_B0), adc.b0);
			check_value("o_adc.b1", words.b1 + 12'(`BIAS_B1), adc.b1);
		end
	endtask

	task automatic pulse_length();
		@(negedge clk);
		test_enable = 1'b1;
		for (int k = 1; k <= 150; k++) begin
			@(negedge clk);
			check_value("o_test_pwm", 12'(k < `TEST_PULSE), 12'(test_pwm));
		end
		test_enable = 1'b0;
	endtask

	// Steady words, then one enabled run up to the LED update
	task automatic run_measurement(input logic [10:0] cur_mag, input logic [10:0] volt_mag);
		int waited;
		@(negedge clk);
		test_enable = 1'b0;
		tx_frame.a0 = sent_word(cur_mag, `BIAS_A0);
		tx_frame.b1 = sent_word(volt_mag, `BIAS_B1);
		repeat (3)
			wait_strobe(waited); // Pipeline holds only the new words
		test_enable = 1'b1;
		repeat (`ACCUM_END)
			@(negedge clk);
		check_value("o_cont_led", 12'd0, 12'(cont_led)); // Not judged yet
		repeat (4)
			@(negedge clk);
	endtask

	task automatic good_igniter();
		logic [11:0] exp_res;
		logic [10:0] exp_mag;
		run_measurement(11'd800, 11'd100); // About 4 ohms
		exp_res = expected_ohms(tx_frame.a0 + 12'(`BIAS_A0), tx_frame.b1 + 12'(`BIAS_B1));
		exp_mag = decode_sample(exp_res);
		check_value("o_res_valid", 12'd1, 12'(res_valid));
		check_value("o_igniter_res", exp_res, igniter_res);
		check_value("o_cont_led", 12'(exp_mag >= 11'(`LED_LO) && exp_mag < 11'(`LED_HI)),
		            12'(cont_led));
		drop_enable();
	endtask

	task automatic open_circuit();
		run_measurement(11'd20, 11'd500); // Current under the minimum
		check_value("o_igniter_res", encode_value(11'(`OPEN_CODE)), igniter_res);
		check_value("o_cont_led", 12'd0, 12'(cont_led));
		drop_enable();
	endtask

	task automatic shorted_igniter();
		logic [11:0] exp_res;
		run_measurement(11'd1600, 11'd20); // Well under 1 ohm
		exp_res = expected_ohms(tx_frame.a0 + 12'(`BIAS_A0), tx_frame.b1 + 12'(`BIAS_B1));
		check_value("o_igniter_res", exp_res, igniter_res);
		check_value("o_cont_led", 12'd0, 12'(cont_led));
		drop_enable();
	endtask

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		ad_sdata_a  = 2'b00;
		ad_sdata_b  = 2'b00;
		test_enable = 1'b0;
		tx_frame    = '0;
		conv_frame  = '0;
		rnd_state   = 32'h21c54519;
		repeat (2)
			@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_reset_state();
		receive_frames(6);
		pulse_length();
		good_igniter();
		open_circuit();
		shorted_igniter();
		$display("errors: %0d testbench checks, %0d checker assertions",
		         errors, UUT.u_checker.fail_count);
		if (errors == 0 && UUT.u_checker.fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
launcher_pkg.sv
adc_serial_rx.sv
ohm_divider.sv
continuity_meter.sv
continuity_top.sv
continuity_checker.sv
continuity_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the continuity testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module continuity_tb -f build.f -o continuity_sim
./obj_dir/continuity_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
